//--- oadc_pkg.sv
`default_nettype none

package oadc_pkg;

   // widths fixed by the ADC and the register bus
   localparam int SAMPLE_W  = 12;
   localparam int GAIN_W    = 8;
   localparam int ADDR_W    = 8;
   localparam int DATA_W    = 8;
   localparam int BYTECNT_W = 7;

   typedef logic [SAMPLE_W-1:0]  sample_t;
   typedef logic [GAIN_W-1:0]    gain_t;
   typedef logic [ADDR_W-1:0]    reg_addr_t;
   typedef logic [DATA_W-1:0]    reg_data_t;
   typedef logic [BYTECNT_W-1:0] bytecnt_t;

   // register map
   localparam reg_addr_t REG_GAIN       = 8'h00;
   localparam reg_addr_t REG_CONTROL    = 8'h01;
   localparam reg_addr_t REG_TRIG_LEVEL = 8'h02;

   // control byte layout
   localparam int CTRL_SRC_BIT  = 0; // 1 = adc input, 0 = test counter
   localparam int CTRL_TRIG_BIT = 1;

   // upper bits of the level that live in byte 1
   localparam int LEVEL_HI_W = SAMPLE_W - DATA_W;

   typedef struct packed {
      logic    data_source_select;
      logic    adc_trigger_active;
      gain_t   gain;
      sample_t trigger_level;
   } frontend_cfg_t;

endpackage

`default_nettype wire

//--- oadc_registers.sv
`timescale 1ns/1ns
`default_nettype none

module oadc_registers
   import oadc_pkg::*;
(
   input  wire                clk_usb,
   input  wire                reset,
   input  wire reg_addr_t     reg_address_i,
   input  wire bytecnt_t      reg_bytecnt_i,
   input  wire reg_data_t     reg_datai_i,
   input  wire                reg_read_i,
   input  wire                reg_write_i,
   output reg_data_t          reg_datao_o,
   output frontend_cfg_t      cfg_o
);

   logic byte0;
   logic byte1;

   assign byte0 = (reg_bytecnt_i == bytecnt_t'(0));
   assign byte1 = (reg_bytecnt_i == bytecnt_t'(1));

   // one byte per write strobe
   always_ff @(posedge clk_usb) begin
      if (reset) begin
         cfg_o <= '0;
      end
      else if (reg_write_i) begin
         case (reg_address_i)
            REG_GAIN: begin
               if (byte0)
                  cfg_o.gain <= reg_datai_i;
            end
            REG_TRIG_LEVEL: begin
               if (byte0)
                  cfg_o.trigger_level[DATA_W-1:0] <= reg_datai_i;
               else if (byte1)
                  cfg_o.trigger_level[SAMPLE_W-1:DATA_W] <= reg_datai_i[LEVEL_HI_W-1:0];
            end
            REG_CONTROL: begin
               if (byte0) begin
                  cfg_o.data_source_select <= reg_datai_i[CTRL_SRC_BIT];
                  cfg_o.adc_trigger_active <= reg_datai_i[CTRL_TRIG_BIT];
               end
            end
            default: ; // unmapped, ignored
         endcase
      end
   end

   // read-back mux, zero when idle or unmapped
   always_comb begin
      reg_datao_o = '0;
      if (reg_read_i) begin
         case (reg_address_i)
            REG_GAIN: begin
               if (byte0)
                  reg_datao_o = cfg_o.gain;
            end
            REG_TRIG_LEVEL: begin
               if (byte0)
                  reg_datao_o = cfg_o.trigger_level[DATA_W-1:0];
               else if (byte1)
                  reg_datao_o = reg_data_t'(cfg_o.trigger_level[SAMPLE_W-1:DATA_W]);
            end
            REG_CONTROL: begin
               if (byte0) begin
                  reg_datao_o[CTRL_SRC_BIT]  = cfg_o.data_source_select;
                  reg_datao_o[CTRL_TRIG_BIT] = cfg_o.adc_trigger_active;
               end
            end
            default: reg_datao_o = '0;
         endcase
      end
   end

endmodule

`default_nettype wire

//--- sample_source.sv
`timescale 1ns/1ns
`default_nettype none

module sample_source
   import oadc_pkg::*;
(
   input  wire                clk_usb,
   input  wire                reset,
   input  wire frontend_cfg_t cfg_i,
   input  wire sample_t       adc_data_i,
   output sample_t            sample_o
);

   sample_t test_count;
   sample_t source_mux;
   sample_t sample_pre;

   assign source_mux = cfg_i.data_source_select ? adc_data_i : test_count;

   // free-running test pattern, wraps at 12 bits
   always_ff @(posedge clk_usb) begin
      if (reset)
         test_count <= '0;
      else
         test_count <= test_count + 1'b1;
   end

   // two-stage resample keeps the capture path alignment
   always_ff @(posedge clk_usb) begin
      if (reset) begin
         sample_pre <= '0;
         sample_o   <= '0;
      end
      else begin
         sample_pre <= source_mux;
         sample_o   <= sample_pre;
      end
   end

endmodule

`default_nettype wire

//--- level_trigger.sv
`timescale 1ns/1ns
`default_nettype none

module level_trigger
   import oadc_pkg::*;
(
   input  wire                clk_usb,
   input  wire                reset,
   input  wire frontend_cfg_t cfg_i,
   input  wire sample_t       sample_i,
   input  wire                armed_and_ready_i,
   output logic               trigger_adc_o
);

   logic armed_r;
   logic armed_rise;
   logic blocked;    // set after a pulse until the next arming
   logic level_hit;
   logic can_fire;
   logic fire;

   assign armed_rise = armed_and_ready_i & ~armed_r;

   // level bit 11 picks the direction
   always_comb begin
      if (cfg_i.trigger_level[SAMPLE_W-1])
         level_hit = (sample_i > cfg_i.trigger_level);
      else
         level_hit = (sample_i < cfg_i.trigger_level);
   end

   assign can_fire = armed_r & cfg_i.adc_trigger_active & ~blocked;
   assign fire     = can_fire & level_hit;

   always_ff @(posedge clk_usb) begin
      if (reset) begin
         armed_r       <= 1'b0;
         trigger_adc_o <= 1'b0;
      end
      else begin
         armed_r       <= armed_and_ready_i;
         trigger_adc_o <= fire;
      end
   end

   // blocking on the firing edge keeps the pulse to one cycle
   always_ff @(posedge clk_usb) begin
      if (reset)
         blocked <= 1'b0;
      else if (fire)
         blocked <= 1'b1;
      else if (armed_rise)
         blocked <= 1'b0; // re-armed
   end

endmodule

`default_nettype wire

//--- gain_pwm.sv
`timescale 1ns/1ns
`default_nettype none

module gain_pwm
   import oadc_pkg::*;
(
   input  wire                clk_usb,
   input  wire                reset,
   input  wire frontend_cfg_t cfg_i,
   output wire                amp_gain_o
);

   logic [GAIN_W:0] pwm_acc; // carry in the top bit

   // carry rate over 256 cycles is gain/256
   always_ff @(posedge clk_usb) begin
      if (reset)
         pwm_acc <= '0;
      else
         pwm_acc <= {1'b0, pwm_acc[GAIN_W-1:0]} + cfg_i.gain;
   end

   assign amp_gain_o = pwm_acc[GAIN_W];

endmodule

`default_nettype wire

//--- adc_front_end.sv
`timescale 1ns/1ns
`default_nettype none

module adc_front_end
   import oadc_pkg::*;
(
   input  wire            clk_usb,
   input  wire            reset,
   input  wire sample_t   adc_data_i,
   input  wire            armed_and_ready_i,

   // register bus
   input  wire reg_addr_t reg_address_i,
   input  wire bytecnt_t  reg_bytecnt_i,
   input  wire reg_data_t reg_datai_i,
   output wire reg_data_t reg_datao_o,
   input  wire            reg_read_i,
   input  wire            reg_write_i,

   output wire            trigger_adc_o,
   output wire            amp_gain_o,
   output wire sample_t   sample_o
);

   wire frontend_cfg_t cfg;
   wire sample_t       sample;

   oadc_registers u_registers (
      .clk_usb        (clk_usb),
      .reset          (reset),
      .reg_address_i  (reg_address_i),
      .reg_bytecnt_i  (reg_bytecnt_i),
      .reg_datai_i    (reg_datai_i),
      .reg_read_i     (reg_read_i),
      .reg_write_i    (reg_write_i),
      .reg_datao_o    (reg_datao_o),
      .cfg_o          (cfg)
   );

   sample_source u_sample_source (
      .clk_usb        (clk_usb),
      .reset          (reset),
      .cfg_i          (cfg),
      .adc_data_i     (adc_data_i),
      .sample_o       (sample)
   );

   level_trigger u_level_trigger (
      .clk_usb           (clk_usb),
      .reset             (reset),
      .cfg_i             (cfg),
      .sample_i          (sample),
      .armed_and_ready_i (armed_and_ready_i),
      .trigger_adc_o     (trigger_adc_o)
   );

   gain_pwm u_gain_pwm (
      .clk_usb        (clk_usb),
      .reset          (reset),
      .cfg_i          (cfg),
      .amp_gain_o     (amp_gain_o)
   );

   assign sample_o = sample;

endmodule

`default_nettype wire

//--- tb_clock_gen.sv
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen (
   output logic clk_o
);

   initial clk_o = 1'b0;

   always #50 clk_o = ~clk_o; // 100 ns period

endmodule

`default_nettype wire

//--- adc_front_end_assertions.sv
`timescale 1ns/1ns
`default_nettype none

module adc_front_end_assertions
   import oadc_pkg::*;
(
   input wire            clk_usb,
   input wire            reset,
   input wire            trigger_adc_o,
   input wire            amp_gain_o,
   input wire sample_t   sample_o,
   input wire reg_data_t reg_datao_o
);

   int unsigned fail_count = 0; // failed assertions so far

   // single-cycle trigger pulse
   trig_one_cycle: assert property (
      @(posedge clk_usb) disable iff (reset) trigger_adc_o |=> !trigger_adc_o
   ) else begin
      fail_count = fail_count + 1;
      $error("trigger_adc_o high for two cycles in a row");
   end

   outputs_known: assert property (
      @(posedge clk_usb) disable iff (reset)
         !$isunknown({trigger_adc_o, amp_gain_o, sample_o, reg_datao_o})
   ) else begin
      fail_count = fail_count + 1;
      $error("unknown value on a DUT output after reset");
   end

endmodule

`default_nettype wire

//--- tb_adc_front_end.sv
`timescale 1ns/1ns
`default_nettype none

module tb_adc_front_end
   import oadc_pkg::*;
();

   localparam logic [31:0] SEED = 32'h0c3bc717;
   localparam int PWM_CYCLES = 4 * 262;

   logic      clk_usb;
   logic      reset;
   sample_t   adc_data_i;
   logic      armed_and_ready_i;
   reg_addr_t reg_address_i;
   bytecnt_t  reg_bytecnt_i;
   reg_data_t reg_datai_i;
   reg_data_t reg_datao_o;
   logic      reg_read_i;
   logic      reg_write_i;
   logic      trigger_adc_o;
   logic      amp_gain_o;
   sample_t   sample_o;

   // step table
   string     s_name[$];
   bit        s_wr[$];
   bit        s_rd[$];
   reg_addr_t s_addr[$];
   bytecnt_t  s_bcnt[$];
   reg_data_t s_data[$];
   bit        s_rand[$];
   sample_t   s_adc[$];
   bit        s_armed[$];
   bit        table_built = 0;

   // reference model state
   frontend_cfg_t m_cfg;
   sample_t       m_cnt, m_pre, m_out;
   logic          m_armed_r, m_blocked, m_trig;
   int            pulses;
   logic [31:0]   rnd;

   tb_clock_gen u_clock (.clk_o(clk_usb));

   adc_front_end UUT (
      .clk_usb           (clk_usb),
      .reset             (reset),
      .adc_data_i        (adc_data_i),
      .armed_and_ready_i (armed_and_ready_i),
      .reg_address_i     (reg_address_i),
      .reg_bytecnt_i     (reg_bytecnt_i),
      .reg_datai_i       (reg_datai_i),
      .reg_datao_o       (reg_datao_o),
      .reg_read_i        (reg_read_i),
      .reg_write_i       (reg_write_i),
      .trigger_adc_o     (trigger_adc_o),
      .amp_gain_o        (amp_gain_o),
      .sample_o          (sample_o)
   );

   bind adc_front_end adc_front_end_assertions u_assertions (
      .clk_usb       (clk_usb),
      .reset         (reset),
      .trigger_adc_o (trigger_adc_o),
      .amp_gain_o    (amp_gain_o),
      .sample_o      (sample_o),
      .reg_datao_o   (reg_datao_o)
   );

   function automatic logic [31:0] xorshift(input logic [31:0] x);
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   task automatic add_step(input string name, input bit wr, input bit rd,
                           input reg_addr_t a, input bytecnt_t b, input reg_data_t d,
                           input bit rand_adc, input sample_t adc, input bit armed);
      s_name.push_back(name);
      s_wr.push_back(wr);
      s_rd.push_back(rd);
      s_addr.push_back(a);
      s_bcnt.push_back(b);
      s_data.push_back(d);
      s_rand.push_back(rand_adc);
      s_adc.push_back(adc);
      s_armed.push_back(armed);
   endtask

   task automatic add_idle(input string name, input int n, input bit rand_adc,
                           input sample_t adc, input bit armed);
      repeat (n) add_step(name, 0, 0, 8'h00, 7'd0, 8'h00, rand_adc, adc, armed);
   endtask

   task automatic build_table();
      // register read-back, level byte 1 keeps 4 bits, control keeps 2
      add_step("reg_gain_wr", 1, 0, REG_GAIN, 7'd0, 8'ha5, 0, 12'h000, 0);
      add_step("reg_lvl0_wr", 1, 0, REG_TRIG_LEVEL, 7'd0, 8'h34, 0, 12'h000, 0);
      add_step("reg_lvl1_wr", 1, 0, REG_TRIG_LEVEL, 7'd1, 8'hf8, 0, 12'h000, 0);
      add_step("reg_ctrl_wr", 1, 0, REG_CONTROL, 7'd0, 8'hff, 0, 12'h000, 0);
      add_step("reg_gain_rd", 0, 1, REG_GAIN, 7'd0, 8'h00, 0, 12'h000, 0);
      add_step("reg_lvl0_rd", 0, 1, REG_TRIG_LEVEL, 7'd0, 8'h00, 0, 12'h000, 0);
      add_step("reg_lvl1_rd", 0, 1, REG_TRIG_LEVEL, 7'd1, 8'h00, 0, 12'h000, 0);
      add_step("reg_ctrl_rd", 0, 1, REG_CONTROL, 7'd0, 8'h00, 0, 12'h000, 0);
      add_step("reg_lvl2_rd", 0, 1, REG_TRIG_LEVEL, 7'd2, 8'h00, 0, 12'h000, 0);
      add_step("reg_unmap_wr", 1, 0, 8'h37, 7'd0, 8'hff, 0, 12'h000, 0);
      add_step("reg_unmap_rd", 0, 1, 8'h37, 7'd0, 8'h00, 0, 12'h000, 0);
      add_step("reg_ctrl_clr", 1, 0, REG_CONTROL, 7'd0, 8'h00, 0, 12'h000, 0);
      add_step("reg_ctrl_rd0", 0, 1, REG_CONTROL, 7'd0, 8'h00, 0, 12'h000, 0);
      add_idle("counter_mode", 12, 0, 12'h000, 0);
      add_step("adc_mode_on", 1, 0, REG_CONTROL, 7'd0, 8'h01, 1, 12'h000, 0);
      add_idle("adc_mode", 16, 1, 12'h000, 0);
      // armed but trigger inactive
      add_idle("trig_inactive", 12, 1, 12'h000, 1);
      add_idle("trig_disarm", 2, 0, 12'h900, 0);
      // level 0x800, bit 11 set, fires above
      add_step("trig_above_l0", 1, 0, REG_TRIG_LEVEL, 7'd0, 8'h00, 0, 12'h900, 0);
      add_step("trig_above_l1", 1, 0, REG_TRIG_LEVEL, 7'd1, 8'h08, 0, 12'h900, 0);
      add_step("trig_above_on", 1, 0, REG_CONTROL, 7'd0, 8'h03, 0, 12'h900, 0);
      add_idle("trig_above", 10, 0, 12'h900, 1);
      add_idle("rearm_low", 3, 0, 12'h900, 0);
      add_idle("rearm_high", 10, 0, 12'h900, 1);
      add_idle("below_disarm", 2, 0, 12'h050, 0);
      // level 0x100, bit 11 clear, fires below
      add_step("trig_below_l0", 1, 0, REG_TRIG_LEVEL, 7'd0, 8'h00, 0, 12'h050, 0);
      add_step("trig_below_l1", 1, 0, REG_TRIG_LEVEL, 7'd1, 8'h01, 0, 12'h050, 0);
      add_idle("trig_below", 10, 0, 12'h050, 1);
   endtask

   function automatic reg_data_t expected_read(input reg_addr_t a, input bytecnt_t b);
      if (a == REG_GAIN && b == 0)
         return m_cfg.gain;
      if (a == REG_TRIG_LEVEL && b == 0)
         return m_cfg.trigger_level[7:0];
      if (a == REG_TRIG_LEVEL && b == 1)
         return {4'h0, m_cfg.trigger_level[11:8]};
      if (a == REG_CONTROL && b == 0)
         return {6'h00, m_cfg.adc_trigger_active, m_cfg.data_source_select};
      return 8'h00;
   endfunction

   // one rising edge of the expected behavior
   task automatic model_edge(input bit wr, input reg_addr_t a, input bytecnt_t b,
                             input reg_data_t d, input sample_t adc, input bit armed);
      logic hit;
      logic fire;
      if (m_cfg.trigger_level[11])
         hit = (m_out > m_cfg.trigger_level);
      else
         hit = (m_out < m_cfg.trigger_level);
      fire = m_armed_r && m_cfg.adc_trigger_active && !m_blocked && hit;
      m_trig = fire;
      if (fire)
         m_blocked = 1'b1;
      else if (armed && !m_armed_r)
         m_blocked = 1'b0;
      m_armed_r = armed;
      m_out = m_pre;
      m_pre = m_cfg.data_source_select ? adc : m_cnt;
      m_cnt = m_cnt + 1'b1;
      if (wr && b == 0 && a == REG_GAIN)
         m_cfg.gain = d;
      if (wr && b == 0 && a == REG_TRIG_LEVEL)
         m_cfg.trigger_level[7:0] = d;
      if (wr && b == 1 && a == REG_TRIG_LEVEL)
         m_cfg.trigger_level[11:8] = d[3:0];
      if (wr && b == 0 && a == REG_CONTROL) begin
         m_cfg.data_source_select = d[0];
         m_cfg.adc_trigger_active = d[1];
      end
   endtask

   task automatic check_value(input string name, input int expected, input int actual);
      assert (expected == actual) else begin
         $display("MISMATCH %s: expected %0h, actual %0h", name, expected, actual);
         $display("Done: errors found");
         $fatal(1);
      end
   endtask

   task automatic check_pwm(input reg_data_t gain);
      int highs;
      highs = 0;
      reg_write_i   = 1'b1;
      reg_address_i = REG_GAIN;
      reg_bytecnt_i = 7'd0;
      reg_datai_i   = gain;
      @(negedge clk_usb);
      reg_write_i = 1'b0;
      repeat (3) @(negedge clk_usb); // let the new gain settle
      repeat (256) begin
         @(negedge clk_usb);
         highs += amp_gain_o;
      end
      check_value("gain_pwm", gain, highs);
   endtask

   // watchdog
   initial begin
      wait (table_built);
      #((s_name.size() * 4 + PWM_CYCLES + 8) * 100);
      $display("timeout: run did not finish in time");
      $display("Done: errors found");
      $fatal(1);
   end

   // bound checker
   initial begin
      wait (UUT.u_assertions.fail_count != 0);
      $display("a bound assertion on the DUT outputs failed");
      $display("Done: errors found");
      $fatal(1);
   end

   initial begin
      sample_t adc;
      reset             = 1'b1;
      adc_data_i        = '0;
      armed_and_ready_i = 1'b0;
      reg_address_i     = '0;
      reg_bytecnt_i     = '0;
      reg_datai_i       = '0;
      reg_read_i        = 1'b0;
      reg_write_i       = 1'b0;
      m_cfg     = '0;
      m_cnt     = '0;
      m_pre     = '0;
      m_out     = '0;
      m_armed_r = 1'b0;
      m_blocked = 1'b0;
      m_trig    = 1'b0;
      pulses    = 0;
      rnd       = SEED;
      build_table();
      table_built = 1;
      repeat (8) @(posedge clk_usb);
      @(negedge clk_usb);
      reset = 1'b0;
      for (int i = 0; i < s_name.size(); i++) begin
         if (s_rand[i]) begin
            rnd = xorshift(rnd);
            adc = rnd[11:0];
         end
         else begin
            adc = s_adc[i];
         end
         adc_data_i        = adc;
         armed_and_ready_i = s_armed[i];
         reg_write_i       = s_wr[i];
         reg_read_i        = s_rd[i];
         reg_address_i     = s_addr[i];
         reg_bytecnt_i     = s_bcnt[i];
         reg_datai_i       = s_data[i];
         @(posedge clk_usb);
         model_edge(s_wr[i], s_addr[i], s_bcnt[i], s_data[i], adc, s_armed[i]);
         @(negedge clk_usb);
         check_value(s_name[i], m_out, sample_o);
         check_value(s_name[i], m_trig, trigger_adc_o);
         pulses += trigger_adc_o;
         if (s_rd[i])
            check_value(s_name[i], expected_read(s_addr[i], s_bcnt[i]), reg_datao_o);
      end
      reg_write_i = 1'b0;
      reg_read_i  = 1'b0;
      // one above, one after re-arm, one below
      check_value("pulse_count", 3, pulses);
      check_pwm(8'h00);
      check_pwm(8'h40);
      check_pwm(8'ha5);
      check_pwm(8'hff);
      $display("Done: no errors");
      $finish;
   end

endmodule

`default_nettype wire

//--- project.f
oadc_pkg.sv
oadc_registers.sv
sample_source.sv
level_trigger.sv
gain_pwm.sv
adc_front_end.sv
tb_clock_gen.sv
adc_front_end_assertions.sv
tb_adc_front_end.sv
